//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing
TOP       ?= tb_ts_replacer
FILELIST  ?= project.f
PASS_MSG  := Regression passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

obj_dir/V$(TOP): $(FILELIST) *.sv
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf obj_dir

//--- pid_lookup_if.sv
`default_nettype none

interface pid_lookup_if
	import ts_pkg::*, replacer_cfg_pkg::*;
();

	logic [TS_PID_WIDTH-1:0] lookup_pid;
	logic                    lookup;

	// answered combinationally by the table
	logic                    hit;
	logic                    change;
	logic                    pts_en;
	logic [GROUP_WIDTH-1:0]  group;
	logic [TS_PTS_WIDTH-1:0] pts;

	modport rewriter (
		output lookup_pid, lookup,
		input  hit, change, pts_en, group, pts
	);

	modport tbl (
		input  lookup_pid, lookup,
		output hit, change, pts_en, group, pts
	);

endinterface

`default_nettype wire

//--- pid_table.sv
`default_nettype none

module pid_table
	import ts_pkg::*, replacer_cfg_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  logic        pid_wr,
	input  logic        pts_wr,
	input  logic [31:0] cfg_index,
	input  pid_cfg_t    cfg_wdata,
	input  logic [32:0] pts_wdata,
	pid_lookup_if.tbl   lk
);

	pid_cfg_t                          slot_cfg   [PID_SLOTS];
	logic [TS_PTS_WIDTH-1:0]           slot_pts   [PID_SLOTS];
	logic [GROUP_WIDTH-1:0]            slot_group [PID_SLOTS];
	logic [$clog2(PTS_TICK_CYCLES)-1:0] tick_cnt;
	logic                              tick;
	logic                              cfg_in_range;
	logic [SLOT_WIDTH-1:0]             wr_slot;
	logic                              hit;
	logic [SLOT_WIDTH-1:0]             win;

	assign cfg_in_range = (cfg_index < PID_SLOTS);
	assign wr_slot = cfg_index[SLOT_WIDTH-1:0];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < PID_SLOTS; i++) begin
				slot_cfg[i].raw <= '0;
			end
		end else if (pid_wr && cfg_in_range) begin
			slot_cfg[wr_slot].raw <= cfg_wdata.raw;
		end
	end

	// free-running 90 kHz style tick, first period starts after reset release
	assign tick = (tick_cnt == PTS_TICK_CYCLES - 1);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			tick_cnt <= '0;
		end else if (tick) begin
			tick_cnt <= '0;
		end else begin
			tick_cnt <= tick_cnt + 1'b1;
		end
	end

	// a written slot takes the new value, the others still advance
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < PID_SLOTS; i++) begin
				slot_pts[i] <= '0;
			end
		end else begin
			for (int i = 0; i < PID_SLOTS; i++) begin
				if (pts_wr && cfg_in_range && wr_slot == SLOT_WIDTH'(i)) begin
					slot_pts[i] <= pts_wdata;
				end else if (tick) begin
					slot_pts[i] <= slot_pts[i] + 1'b1;
				end
			end
		end
	end

	// lowest enabled slot with a matching PID wins
	always_comb begin
		hit = 1'b0;
		win = '0;
		for (int i = PID_SLOTS - 1; i >= 0; i--) begin
			if (slot_cfg[i].fields.match_en && slot_cfg[i].fields.pid == lk.lookup_pid) begin
				hit = 1'b1;
				win = SLOT_WIDTH'(i);
			end
		end
	end

	assign lk.hit    = hit;
	assign lk.change = slot_cfg[win].fields.change_en;
	assign lk.pts_en = slot_cfg[win].fields.pts_en;
	assign lk.group  = slot_group[win];
	assign lk.pts    = slot_pts[win];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < PID_SLOTS; i++) begin
				slot_group[i] <= '0;
			end
		end else if (lk.lookup && hit) begin
			if (slot_group[win] == GROUP_WIDTH'(REPLACE_GROUPS - 1)) begin
				slot_group[win] <= '0;
			end else begin
				slot_group[win] <= slot_group[win] + 1'b1;
			end
		end
	end

	for (genvar g = 0; g < PID_SLOTS; g++) begin : g_group_chk
		a_group_range: assert property (@(posedge clk) disable iff (!rst_n)
			int'(slot_group[g]) < REPLACE_GROUPS);
	end

endmodule

`default_nettype wire

//--- project.f
ts_pkg.sv
replacer_cfg_pkg.sv
pid_lookup_if.sv
pid_table.sv
replace_ram.sv
ts_rewriter.sv
ts_replacer_top.sv
tb_checker.sv
tb_ts_replacer.sv

//--- replace_ram.sv
`default_nettype none

module replace_ram
	import replacer_cfg_pkg::*;
(
	input  logic        clk,
	input  logic        data_wr,
	input  logic [31:0] cfg_index,
	input  logic [31:0] cfg_wdata,
	input  logic [31:0] rd_byte_addr,
	output logic [7:0]  rd_byte
);

	logic [CFG_DATA_WIDTH-1:0] mem [RAM_WORDS];
	logic [29:0]               rd_word;
	logic [1:0]                rd_lane;

	always_ff @(posedge clk) begin
		if (data_wr && cfg_index < RAM_WORDS) begin
			mem[cfg_index[RAM_ADDR_WIDTH-1:0]] <= cfg_wdata;
		end
	end

	// lane 0 sits in the low byte of each word
	assign rd_word = rd_byte_addr[31:2];
	assign rd_lane = rd_byte_addr[1:0];

	always_comb begin
		if (rd_word < RAM_WORDS) begin
			rd_byte = mem[rd_word[RAM_ADDR_WIDTH-1:0]][rd_lane*8 +: 8];
		end else begin
			rd_byte = 8'h00;
		end
	end

endmodule

`default_nettype wire

//--- replacer_cfg_pkg.sv
`default_nettype none

package replacer_cfg_pkg;

	localparam int PID_SLOTS = 4;
	localparam int REPLACE_GROUPS = 2;
	localparam int CFG_DATA_WIDTH = 32;

	// 47 words of 32 bits per stored packet
	localparam int RAM_WORDS = REPLACE_GROUPS * 47;
	localparam int RAM_ADDR_WIDTH = $clog2(RAM_WORDS);

	localparam int PTS_TICK_CYCLES = 1390;

	localparam int SLOT_WIDTH = (PID_SLOTS > 1) ? $clog2(PID_SLOTS) : 1;
	localparam int GROUP_WIDTH = (REPLACE_GROUPS > 1) ? $clog2(REPLACE_GROUPS) : 1;

	typedef struct packed {
		logic [12:0] reserved;
		logic        pts_en;
		logic        change_en;
		logic        match_en;
		logic [2:0]  pad;
		logic [12:0] pid;
	} pid_cfg_fields_t;

	// same word as written on the config bus and as decoded per slot
	typedef union packed {
		logic [CFG_DATA_WIDTH-1:0] raw;
		pid_cfg_fields_t           fields;
	} pid_cfg_t;

endpackage

`default_nettype wire

//--- replacer_stim.txt
# P slot word | T slot pts | D word_index word | E enable | N test_name
# K pid packet_count idle_gap   (slot, index, word, pid in hex; count, gap in decimal)
D 0 deadbeef
D 2f 12345678
D 35 cafef00d
D 36 0badf00d
N no_match
P 0 00010100
P 1 00000200
E 0
K 100 2 0
E 1
K 123 2 0
K 200 1 0
N plain_match
K 100 3 0
N change_pid
P 2 00020300
K 300 2 1
N rotation
P 3 00010100
P 1 00010200
K 200 1 0
K 100 1 0
K 200 1 0
K 100 1 0
N pts_insert
T 0 100000005
P 0 00050100
K 100 4 3
N out_of_range
P 7 00010123
D c8 ffffffff
K 123 1 0
K 1fff 1 0

//--- tb_checker.sv
`default_nettype none

module tb_checker
	import ts_pkg::*, replacer_cfg_pkg::*;
(
	input  wire logic        clk,
	input  wire logic        rst_n,
	input  wire logic        pid_wr,
	input  wire logic        pts_wr,
	input  wire logic        data_wr,
	input  wire logic [31:0] cfg_index,
	input  wire logic [31:0] cfg_wdata,
	input  wire logic [32:0] pts_wdata,
	input  wire logic        match_enable,
	input  wire logic [7:0]  ts_in,
	input  wire logic        ts_in_valid,
	input  wire logic        ts_in_sync,
	input  wire logic [7:0]  ts_out,
	input  wire logic        ts_out_valid,
	input  wire logic        ts_out_sync,
	input  wire logic [31:0] matched_count,
	output int               error_count
);
	timeunit 1ns;
	timeprecision 1ps;

	pid_cfg_t cfg [PID_SLOTS];
	logic [32:0] pts [PID_SLOTS];
	int grp [PID_SLOTS];
	logic [31:0] ram [RAM_WORDS];
	longint cyc;
	logic [7:0] h1, h2, h3;
	logic f1, f2;
	bit in_pkt;
	int idx;
	bit m_change, m_pts_en;
	int m_grp;
	logic [32:0] m_pts;
	logic [31:0] count;
	bit exp_valid, exp_sync;
	logic [7:0] exp_byte;

	function automatic logic [7:0] ram_byte(input int a);
		logic [31:0] w;
		w = ram[a / 4];
		return w[(a % 4) * 8 +: 8];
	endfunction

	// output byte i of the current packet built from the delayed input byte in h3
	function automatic logic [7:0] expected_byte(input int i);
		logic [7:0] r;
		r = ram_byte(m_grp * TS_PACKET_BYTES + i);
		if (m_pts_en && m_grp == 0 && i >= TS_PTS_OFFSET && i < TS_PTS_OFFSET + 5) begin
			case (i - TS_PTS_OFFSET)
				0: return {4'b0010, m_pts[32:30], 1'b1};
				1: return m_pts[29:22];
				2: return {m_pts[21:15], 1'b1};
				3: return m_pts[14:7];
				default: return {m_pts[6:0], 1'b1};
			endcase
		end
		case (i)
			0: return h3;
			1: return {h3[7], m_grp == 0, h3[5], m_change ? r[4:0] : h3[4:0]};
			2: return m_change ? r : h3;
			3: return {h3[7:6], 2'b11, h3[3:0]};
			default: return r;
		endcase
	endfunction

	always @(posedge clk) begin
		int slot;
		bit tick;
		if (!rst_n) begin
			for (int i = 0; i < PID_SLOTS; i++) begin
				cfg[i].raw = '0;
				pts[i] = '0;
				grp[i] = 0;
			end
			cyc = 0;
			f1 = 1'b0;
			f2 = 1'b0;
			in_pkt = 1'b0;
			idx = 0;
			count = '0;
			exp_valid = 1'b0;
			error_count = 0;
		end else begin
			if (exp_valid && !ts_out_valid) begin
				$display("expected output byte %0d did not appear", idx - 1);
				error_count++;
			end else if (!exp_valid && ts_out_valid) begin
				$display("output strobe seen while no packet byte was expected");
				error_count++;
			end else if (exp_valid) begin
				if (ts_out !== exp_byte) begin
					$display("Fail ts_out: expected %h, got %h", exp_byte, ts_out);
					error_count++;
				end
				if (ts_out_sync !== exp_sync) begin
					$display("Fail ts_out_sync: expected %h, got %h", exp_sync, ts_out_sync);
					error_count++;
				end
			end else if (ts_out_sync !== 1'b0) begin
				$display("Fail ts_out_sync: expected %h, got %h", 1'b0, ts_out_sync);
				error_count++;
			end
			if (matched_count !== count) begin
				$display("Fail matched_count: expected %h, got %h", count, matched_count);
				error_count++;
			end
			exp_valid = 1'b0;
			cyc++;
			tick = (cyc % PTS_TICK_CYCLES == 0);
			if (ts_in_valid) begin
				if (in_pkt && idx < TS_PACKET_BYTES) begin
					exp_valid = 1'b1;
					exp_byte = expected_byte(idx);
					exp_sync = (idx == 0);
					idx++;
				end
				if (f2 && h2 == TS_SYNC_BYTE) begin
					slot = -1;
					for (int i = PID_SLOTS - 1; i >= 0; i--) begin
						if (cfg[i].fields.match_en && cfg[i].fields.pid == {h1[4:0], ts_in})
							slot = i;
					end
					in_pkt = (slot >= 0) && match_enable;
					if (in_pkt) begin
						idx = 0;
						m_change = cfg[slot].fields.change_en;
						m_pts_en = cfg[slot].fields.pts_en;
						m_grp = grp[slot];
						m_pts = pts[slot];
						count++;
					end
					if (slot >= 0) grp[slot] = (grp[slot] + 1) % REPLACE_GROUPS;
				end
				h3 = h2;
				h2 = h1;
				h1 = ts_in;
				f2 = f1;
				f1 = ts_in_sync;
			end
			if (pid_wr && cfg_index < PID_SLOTS) cfg[cfg_index].raw = cfg_wdata;
			for (int i = 0; i < PID_SLOTS; i++) begin
				if (pts_wr && cfg_index == i) pts[i] = pts_wdata;
				else if (tick) pts[i] = pts[i] + 1'b1;
			end
			if (data_wr && cfg_index < RAM_WORDS) ram[cfg_index] = cfg_wdata;
		end
	end

endmodule

`default_nettype wire

//--- tb_ts_replacer.sv
`default_nettype none

module tb_ts_replacer
	import ts_pkg::*, replacer_cfg_pkg::*;
;
	timeunit 1ns;
	timeprecision 1ps;

	logic clk = 1'b0;
	logic rst_n;
	logic pid_wr, pts_wr, data_wr;
	logic [31:0] cfg_index;
	logic [CFG_DATA_WIDTH-1:0] cfg_wdata;
	logic [TS_PTS_WIDTH-1:0] pts_wdata;
	logic match_enable;
	logic [7:0] ts_in;
	logic ts_in_valid, ts_in_sync;
	logic [7:0] ts_out;
	logic ts_out_valid, ts_out_sync;
	logic [CFG_DATA_WIDTH-1:0] matched_count;
	int error_count;

	string cmds[$];
	logic [31:0] lfsr = 32'h532f_9ea0;
	longint cycles = 0;
	longint limit = 64'h7fff_ffff_ffff;
	string test_name = "";
	int test_start_err = 0;
	int tests_run = 0;
	int tests_failed = 0;

	ts_replacer_top UUT (.*);

	tb_checker chk (.*);

	always #50 clk = ~clk;

	always @(posedge clk) begin
		cycles++;
		if (cycles > limit) begin
			$display("run stopped: no progress within %0d cycles", limit);
			$display("Regression failed");
			$finish;
		end
	end

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic next_rand(output logic [7:0] b);
		for (int k = 0; k < 8; k++) begin
			lfsr = lfsr_step(lfsr);
			b = {b[6:0], lfsr[0]};
		end
	endtask

	// one cycle of bus activity with all strobes back to idle
	task automatic step();
		@(posedge clk);
		#1;
		pid_wr = 1'b0;
		pts_wr = 1'b0;
		data_wr = 1'b0;
		ts_in_valid = 1'b0;
		ts_in_sync = 1'b0;
	endtask

	task automatic send_packet(input logic [12:0] pid, input int gap);
		logic [7:0] pkt [TS_PACKET_BYTES];
		for (int i = 0; i < TS_PACKET_BYTES; i++) begin
			next_rand(pkt[i]);
		end
		pkt[0] = TS_SYNC_BYTE;
		pkt[1] = {pkt[1][7], 1'b0, pkt[1][5], pid[12:8]};
		pkt[2] = pid[7:0];
		pkt[3][5:4] = 2'b00;
		for (int i = 0; i < TS_PACKET_BYTES; i++) begin
			step();
			ts_in = pkt[i];
			ts_in_valid = 1'b1;
			ts_in_sync = (i == 0);
			repeat (gap) step();
		end
	endtask

	task automatic close_test();
		int errs;
		if (test_name != "") begin
			errs = error_count - test_start_err;
			tests_run++;
			if (errs != 0) tests_failed++;
			$display("test %s: %0d errors", test_name, errs);
		end
	endtask

	initial begin
		int fd;
		int rc;
		string line;
		byte c;
		logic [63:0] a, b;
		int n, g;
		string name;
		longint budget;
		bit open_failed;
		rst_n = 1'b0;
		pid_wr = 1'b0;
		pts_wr = 1'b0;
		data_wr = 1'b0;
		cfg_index = '0;
		cfg_wdata = '0;
		pts_wdata = '0;
		match_enable = 1'b0;
		ts_in = '0;
		ts_in_valid = 1'b0;
		ts_in_sync = 1'b0;
		open_failed = 1'b0;
		fd = $fopen("replacer_stim.txt", "r");
		if (fd == 0) begin
			$display("could not open the stimulus file replacer_stim.txt");
			open_failed = 1'b1;
		end else begin
			while (!$feof(fd)) begin
				rc = $fgets(line, fd);
				if (rc > 1 && line.getc(0) != "#") cmds.push_back(line);
			end
			$fclose(fd);
		end
		// timeout budget from packet beats, writes and a margin
		budget = RAM_WORDS + 500;
		foreach (cmds[i]) begin
			c = cmds[i].getc(0);
			if (c == "K") begin
				rc = $sscanf(cmds[i], "%c %h %d %d", c, a, n, g);
				budget += longint'(n) * TS_PACKET_BYTES * (1 + g);
			end else if (c != "N") begin
				budget += 1;
			end
		end
		limit = budget;
		repeat (3) @(posedge clk);
		#1;
		rst_n = 1'b1;
		// fill pattern over the whole word index
		for (int w = 0; w < RAM_WORDS; w++) begin
			step();
			data_wr = 1'b1;
			cfg_index = w;
			cfg_wdata = {8'(w), 8'(w ^ 8'h5a), 8'(w * 3 + 1), ~8'(w)};
		end
		foreach (cmds[i]) begin
			c = cmds[i].getc(0);
			case (c)
				"P", "T", "D": begin
					rc = $sscanf(cmds[i], "%c %h %h", c, a, b);
					step();
					cfg_index = a[31:0];
					cfg_wdata = b[31:0];
					pts_wdata = b[32:0];
					pid_wr = (c == "P");
					pts_wr = (c == "T");
					data_wr = (c == "D");
				end
				"E": begin
					rc = $sscanf(cmds[i], "%c %h", c, a);
					step();
					match_enable = a[0];
				end
				"K": begin
					rc = $sscanf(cmds[i], "%c %h %d %d", c, a, n, g);
					repeat (n) send_packet(a[12:0], g);
				end
				"N": begin
					rc = $sscanf(cmds[i], "%c %s", c, name);
					close_test();
					test_name = name;
					test_start_err = error_count;
				end
				default: $display("unknown stimulus command: %s", cmds[i]);
			endcase
		end
		repeat (4) step();
		close_test();
		$display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, error_count);
		if (!open_failed && error_count == 0 && tests_failed == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- ts_pkg.sv
`default_nettype none

package ts_pkg;

	// MPEG-2 transport stream packet framing
	localparam int TS_PACKET_BYTES = 188;
	localparam logic [7:0] TS_SYNC_BYTE = 8'h47;

	// wide enough to count one past the last byte of a packet
	localparam int TS_INDEX_WIDTH = 8;

	// header PID field, split over bytes 1 and 2
	localparam int TS_PID_WIDTH = 13;

	// PES presentation time stamp, bytes 24 to 28
	localparam int TS_PTS_OFFSET = 24;
	localparam int TS_PTS_WIDTH = 33;

endpackage

`default_nettype wire

//--- ts_replacer_top.sv
`default_nettype none

module ts_replacer_top
	import ts_pkg::*, replacer_cfg_pkg::*;
(
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      pid_wr,
	input  logic                      pts_wr,
	input  logic                      data_wr,
	input  logic [31:0]               cfg_index,
	input  logic [CFG_DATA_WIDTH-1:0] cfg_wdata,
	input  logic [TS_PTS_WIDTH-1:0]   pts_wdata,
	input  logic                      match_enable,
	input  logic [7:0]                ts_in,
	input  logic                      ts_in_valid,
	input  logic                      ts_in_sync,
	output logic [7:0]                ts_out,
	output logic                      ts_out_valid,
	output logic                      ts_out_sync,
	output logic [CFG_DATA_WIDTH-1:0] matched_count
);

	logic [31:0] rd_byte_addr;
	logic [7:0]  rd_byte;

	pid_lookup_if lk_if ();

	pid_table u_pid_table (
		.clk       (clk),
		.rst_n     (rst_n),
		.pid_wr    (pid_wr),
		.pts_wr    (pts_wr),
		.cfg_index (cfg_index),
		.cfg_wdata (cfg_wdata),
		.pts_wdata (pts_wdata),
		.lk        (lk_if.tbl)
	);

	replace_ram u_replace_ram (
		.clk          (clk),
		.data_wr      (data_wr),
		.cfg_index    (cfg_index),
		.cfg_wdata    (cfg_wdata),
		.rd_byte_addr (rd_byte_addr),
		.rd_byte      (rd_byte)
	);

	ts_rewriter u_ts_rewriter (
		.clk           (clk),
		.rst_n         (rst_n),
		.match_enable  (match_enable),
		.ts_in         (ts_in),
		.ts_in_valid   (ts_in_valid),
		.ts_in_sync    (ts_in_sync),
		.lk            (lk_if.rewriter),
		.rd_byte_addr  (rd_byte_addr),
		.rd_byte       (rd_byte),
		.ts_out        (ts_out),
		.ts_out_valid  (ts_out_valid),
		.ts_out_sync   (ts_out_sync),
		.matched_count (matched_count)
	);

endmodule

`default_nettype wire

//--- ts_rewriter.sv
`default_nettype none

module ts_rewriter
	import ts_pkg::*, replacer_cfg_pkg::*;
(
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      match_enable,
	input  logic [7:0]                ts_in,
	input  logic                      ts_in_valid,
	input  logic                      ts_in_sync,
	pid_lookup_if.rewriter            lk,
	output logic [31:0]               rd_byte_addr,
	input  logic [7:0]                rd_byte,
	output logic [7:0]                ts_out,
	output logic                      ts_out_valid,
	output logic                      ts_out_sync,
	output logic [CFG_DATA_WIDTH-1:0] matched_count
);

	logic [7:0]                d1;
	logic [7:0]                d2;
	logic [7:0]                d3;
	logic                      s1;
	logic                      s2;
	logic                      hdr;
	logic                      take;
	logic                      matched;
	logic                      emit;
	logic [TS_INDEX_WIDTH-1:0] pkt_idx;
	logic                      cur_change;
	logic                      cur_pts_en;
	logic [GROUP_WIDTH-1:0]    cur_group;
	logic [TS_PTS_WIDTH-1:0]   cur_pts;
	logic                      first_group;
	logic [7:0]                out_byte;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			s1 <= 1'b0;
			s2 <= 1'b0;
		end else if (ts_in_valid) begin
			s1 <= ts_in_sync;
			s2 <= s1;
		end
	end

	always_ff @(posedge clk) begin
		if (ts_in_valid) begin
			d1 <= ts_in;
			d2 <= d1;
			d3 <= d2;
		end
	end

	// sync byte two beats back, so ts_in is the low PID byte
	assign hdr = ts_in_valid && s2 && (d2 == TS_SYNC_BYTE);
	assign take = hdr && lk.hit && match_enable;

	assign lk.lookup = hdr;
	assign lk.lookup_pid = {d1[4:0], ts_in};

	assign emit = ts_in_valid && matched && (pkt_idx < TS_PACKET_BYTES);
	assign first_group = (cur_group == '0);

	assign rd_byte_addr = 32'(cur_group) * 32'(TS_PACKET_BYTES) + 32'(pkt_idx);

	always_comb begin
		case (pkt_idx)
			8'd0: out_byte = d3;
			// payload start marks group 0 only
			8'd1: out_byte = {d3[7], first_group, d3[5],
				cur_change ? rd_byte[4:0] : d3[4:0]};
			8'd2: out_byte = cur_change ? rd_byte : d3;
			// adaptation field and payload both present
			8'd3: out_byte = {d3[7:6], 2'b11, d3[3:0]};
			default: out_byte = rd_byte;
		endcase
		if (cur_pts_en && first_group) begin
			case (pkt_idx)
				TS_PTS_OFFSET:     out_byte = {4'b0010, cur_pts[32:30], 1'b1};
				TS_PTS_OFFSET + 1: out_byte = cur_pts[29:22];
				TS_PTS_OFFSET + 2: out_byte = {cur_pts[21:15], 1'b1};
				TS_PTS_OFFSET + 3: out_byte = cur_pts[14:7];
				TS_PTS_OFFSET + 4: out_byte = {cur_pts[6:0], 1'b1};
				default: out_byte = out_byte;
			endcase
		end
	end

	// the last byte of a packet leaves on the same beat as the next lookup
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			matched <= 1'b0;
			pkt_idx <= '0;
			matched_count <= '0;
			ts_out_valid <= 1'b0;
			ts_out_sync <= 1'b0;
		end else begin
			ts_out_valid <= 1'b0;
			ts_out_sync <= 1'b0;
			if (emit) begin
				ts_out_valid <= 1'b1;
				ts_out_sync <= (pkt_idx == '0);
				pkt_idx <= pkt_idx + 1'b1;
			end
			if (hdr) begin
				matched <= take;
				if (take) begin
					pkt_idx <= '0;
					matched_count <= matched_count + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (emit) begin
			ts_out <= out_byte;
		end
		if (take) begin
			cur_change <= lk.change;
			cur_pts_en <= lk.pts_en;
			cur_group <= lk.group;
			cur_pts <= lk.pts;
		end
	end

	a_valid_needs_match: assert property (@(posedge clk) disable iff (!rst_n)
		ts_out_valid |-> $past(matched));

	// holds for well-formed 188 byte framing on the input
	a_index_range: assert property (@(posedge clk) disable iff (!rst_n)
		(ts_in_valid && matched) |-> (pkt_idx < TS_PACKET_BYTES));

endmodule

`default_nettype wire
